/* rtl/alu_pkg.sv */
// alu package: widths, Booth step count, opcodes and one-hot state indices
`default_nettype none

package alu_pkg;

    // operand and bus width
    localparam int DATA_W = 8;

    // two guard bits on A so that A +/- 2M cannot overflow during a Booth step
    localparam int GUARD_W = 2;
    localparam int ACC_W = DATA_W + GUARD_W;  // 10 bits

    // radix-4 retires two multiplier bits per iteration
    localparam int RADIX4_STEPS = DATA_W / 2;
    localparam int CNT_W = $clog2(RADIX4_STEPS);  // step counter width, 2 bits

    // opcodes, as sampled with start
    typedef enum logic [1:0] {
        OP_ADD  = 2'b00,  // A + M, wraps mod 256
        OP_SUB  = 2'b01,  // A - M, wraps mod 256
        OP_MUL  = 2'b10,  // radix-4 Booth, 16-bit product
        OP_RSVD = 2'b11   // reserved, start is ignored
    } op_e;

    // bit positions inside the one-hot state vector
    typedef enum int unsigned {
        IDLE          = 0,
        LOADA         = 1,  // A from inbus
        LOADQ         = 2,  // multiplier into Q, A and Q[-1] cleared
        LOADM         = 3,  // M from inbus, counter cleared
        ADDMTOA       = 4,  // A := A +/- M or 2M
        PUSHA         = 5,  // A[7:0] on outbus
        PUSHQ         = 6,  // Q on outbus
        RSHIFT        = 7,  // first of the two shifts
        RSHIFT_DOUBLE = 8,  // second shift
        COUNT_RSHIFTS = 9   // step counter increment
    } state_idx_e;

    localparam int NUM_STATES = 10;

    // one flop per state
    typedef logic [NUM_STATES-1:0] state_vec_t;

endpackage

`default_nettype wire

/* rtl/alu_ctrl_if.sv */
// controller/datapath link: strobes go to the datapath, Booth bits and counter status come back
`default_nettype none

interface alu_ctrl_if;

    // register loads
    logic load_a;  // A <= sign-extended inbus
    logic load_q;  // Q <= inbus
    logic load_m;  // M <= inbus
    logic init_a;  // clear A and Q[-1] before a multiply

    // adder
    logic add_en;   // A <= A +/- operand
    logic sel_sub;  // subtract instead of add
    logic sel_2m;   // operand is 2M, else M

    logic rshift;  // arithmetic shift of {A, Q, Q[-1]}

    // step counter
    logic count_clr;
    logic count_inc;

    // output bus selects
    logic push_a;
    logic push_q;

    // status back to the controller
    logic [2:0] q_bits;  // {Q[1], Q[0], Q[-1]}
    logic count_full;    // last Booth iteration

    modport ctrl (
        output load_a, load_q, load_m, init_a,
        output add_en, sel_sub, sel_2m, rshift,
        output count_clr, count_inc, push_a, push_q,
        input  q_bits, count_full
    );

    modport dp (
        input  load_a, load_q, load_m, init_a,
        input  add_en, sel_sub, sel_2m, rshift,
        input  count_clr, count_inc, push_a, push_q,
        output q_bits, count_full
    );

endinterface

`default_nettype wire

/* rtl/booth_control.sv */
// one-hot control unit sequencing loads, Booth adds, shifts, counting and output pushes
`default_nettype none

module booth_control import alu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,      // one cycle in IDLE
    input  op_e    op,         // valid with start only
    alu_ctrl_if.ctrl bus,
    output logic   out_valid,  // outbus carries a result byte
    output logic   done        // last byte of the operation
);

    state_vec_t state;       // current state, exactly one bit set
    state_vec_t next_state;

    op_e op_q;  // opcode held for the whole operation

    logic is_mul;     // latched op is a multiply
    logic add_step;   // Booth digit is nonzero, ADDMTOA needed
    logic two_m;      // Booth digit is +/-2
    logic go;         // accepted start

    // decisional wires

    assign is_mul = (op_q == OP_MUL);

    // 000 and 111 are digit 0, skip the add
    assign add_step = ~((bus.q_bits == 3'b000) | (bus.q_bits == 3'b111));

    // 011 -> +2M, 100 -> -2M
    assign two_m = (bus.q_bits == 3'b011) | (bus.q_bits == 3'b100);

    // reserved op never leaves IDLE
    assign go = state[IDLE] & start & (op != OP_RSVD);

    // state register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= '0;
            state[IDLE] <= 1'b1;  // IDLE gets the jumpstart
        end else begin
            state <= next_state;
        end
    end

    // opcode latch, only in IDLE
    always_ff @(posedge clk) begin
        if (!rst_n)
            op_q <= OP_ADD;
        else if (go)
            op_q <= op;
    end

    // next state, one equation per flop

    always_comb begin
        next_state = '0;

        // waiting, or graceful end of an operation
        next_state[IDLE] = (state[IDLE] & ~go)
                         | (state[PUSHA] & ~is_mul)  // add, sub end
                         | state[PUSHQ];             // mul end

        // operand loading
        next_state[LOADA] = go & (op != OP_MUL);  // add, sub
        next_state[LOADQ] = go & (op == OP_MUL);
        next_state[LOADM] = state[LOADA] | state[LOADQ];

        // adder: always for add/sub, on a nonzero digit for mul
        next_state[ADDMTOA] = (state[LOADM] & ~is_mul)
                            | (state[LOADM] & is_mul & add_step)
                            | (state[COUNT_RSHIFTS] & add_step);

        // first shift of an iteration, after the add or in its place
        next_state[RSHIFT] = (state[ADDMTOA] & is_mul)
                           | (state[LOADM] & is_mul & ~add_step)
                           | (state[COUNT_RSHIFTS] & ~add_step);

        next_state[RSHIFT_DOUBLE] = state[RSHIFT];

        // the last iteration skips the count and goes straight to output
        next_state[COUNT_RSHIFTS] = state[RSHIFT_DOUBLE] & ~bus.count_full;

        // output
        next_state[PUSHA] = (state[ADDMTOA] & ~is_mul)
                          | (state[RSHIFT_DOUBLE] & bus.count_full);
        next_state[PUSHQ] = state[PUSHA] & is_mul;  // low byte of the product
    end

    // control strobes, Moore outputs of the current state

    // loads
    assign bus.load_a = state[LOADA];
    assign bus.load_q = state[LOADQ];
    assign bus.init_a = state[LOADQ];  // A and Q[-1] start from zero for mul
    assign bus.load_m = state[LOADM];

    // counter
    assign bus.count_clr = state[LOADM];
    assign bus.count_inc = state[COUNT_RSHIFTS];

    // adder and its operand selects
    assign bus.add_en  = state[ADDMTOA];
    assign bus.sel_2m  = state[ADDMTOA] & is_mul & two_m;
    assign bus.sel_sub = state[ADDMTOA]
                       & ((op_q == OP_SUB)                // for dif
                        | (is_mul & bus.q_bits[2]));      // negative Booth digit

    // both shift states move by one bit
    assign bus.rshift = state[RSHIFT] | state[RSHIFT_DOUBLE];

    // outbus selects
    assign bus.push_a = state[PUSHA];
    assign bus.push_q = state[PUSHQ];

    // external handshake
    assign out_valid = state[PUSHA] | state[PUSHQ];
    assign done      = (state[PUSHA] & ~is_mul) | state[PUSHQ];

    // exactly one state active at any time
    a_state_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(state)
    );

    // done never comes without a byte on the bus
    a_done_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> out_valid
    );

endmodule

`default_nettype wire

/* rtl/booth_datapath.sv */
// Booth datapath: A/Q/Q[-1]/M registers, add/sub of M or 2M, arithmetic shifter and step counter
`default_nettype none

module booth_datapath import alu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] inbus,
    output logic [DATA_W-1:0] outbus,
    alu_ctrl_if.dp            bus
);

    logic [ACC_W-1:0]  a_reg;  // accumulator with guard bits
    logic [DATA_W-1:0] q_reg;  // multiplier, low product byte at the end
    logic              q_m1;   // Q[-1]
    logic [DATA_W-1:0] m_reg;  // multiplicand or second operand

    logic [CNT_W-1:0]  count;  // Radix-4 iterations done

    logic [ACC_W-1:0]  m_ext;    // M sign-extended
    logic [ACC_W-1:0]  m2_ext;   // 2M sign-extended
    logic [ACC_W-1:0]  operand;  // adder operand, M or 2M
    logic [ACC_W-1:0]  sum;      // adder result

    logic [ACC_W-1:0]  a_load;   // inbus sign-extended for add/sub

    // operand select
    assign m_ext   = {{GUARD_W{m_reg[DATA_W-1]}}, m_reg};
    assign m2_ext  = {{(GUARD_W-1){m_reg[DATA_W-1]}}, m_reg, 1'b0};  // shift left by one
    assign operand = bus.sel_2m ? m2_ext : m_ext;

    // single adder, subtraction when sel_sub
    assign sum = bus.sel_sub ? (a_reg - operand) : (a_reg + operand);

    assign a_load = {{GUARD_W{inbus[DATA_W-1]}}, inbus};

    // A register
    // the controller never raises two of these in one cycle
    always_ff @(posedge clk) begin
        if (bus.load_a)
            a_reg <= a_load;
        else if (bus.init_a)
            a_reg <= '0;
        else if (bus.add_en)
            a_reg <= sum;
        else if (bus.rshift)
            a_reg <= {a_reg[ACC_W-1], a_reg[ACC_W-1:1]};  // sign kept
    end

    // Q register, LSb of A shifts in at the top
    always_ff @(posedge clk) begin
        if (bus.load_q)
            q_reg <= inbus;
        else if (bus.rshift)
            q_reg <= {a_reg[0], q_reg[DATA_W-1:1]};
    end

    // Q[-1] catches the bit falling out of Q
    always_ff @(posedge clk) begin
        if (bus.init_a)
            q_m1 <= 1'b0;
        else if (bus.rshift)
            q_m1 <= q_reg[0];
    end

    // M register
    always_ff @(posedge clk) begin
        if (bus.load_m)
            m_reg <= inbus;
    end

    // Radix-4 step counter
    always_ff @(posedge clk) begin
        if (!rst_n)
            count <= '0;
        else if (bus.count_clr)
            count <= '0;
        else if (bus.count_inc)
            count <= count + 1'b1;
    end

    // status to the controller
    assign bus.q_bits     = {q_reg[1], q_reg[0], q_m1};  // Booth recoding window
    assign bus.count_full = (count == CNT_W'(RADIX4_STEPS - 1));

    // output bus, zero when nothing is pushed
    always_comb begin
        if (bus.push_a)
            outbus = a_reg[DATA_W-1:0];  // result or high product byte
        else if (bus.push_q)
            outbus = q_reg;              // low product byte
        else
            outbus = '0;
    end

    // A has one writer per cycle
    a_a_write_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({bus.load_a, bus.add_en, bus.rshift})
    );

    // one byte on the bus at a time
    a_push_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(bus.push_a && bus.push_q)
    );

    // the counter never wraps, the last iteration skips the increment
    a_count_no_wrap : assert property (
        @(posedge clk) disable iff (!rst_n)
        bus.count_inc |-> !bus.count_full
    );

endmodule

`default_nettype wire

/* rtl/booth_alu_top.sv */
// sequential ALU top: add, sub and radix-4 Booth multiply on a byte-wide bus
`default_nettype none

module booth_alu_top import alu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,      // one cycle, with op
    input  op_e               op,
    input  logic [DATA_W-1:0] inbus,      // operands in the two cycles after start
    output logic [DATA_W-1:0] outbus,
    output logic              out_valid,
    output logic              done
);

    // strobes and status between the two blocks
    alu_ctrl_if ctrl_bus ();

    // one-hot FSM
    booth_control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .op        (op),
        .bus       (ctrl_bus.ctrl),
        .out_valid (out_valid),
        .done      (done)
    );

    // registers, adder, shifter, counter
    booth_datapath u_datapath (
        .clk    (clk),
        .rst_n  (rst_n),
        .inbus  (inbus),
        .outbus (outbus),
        .bus    (ctrl_bus.dp)
    );

endmodule

`default_nettype wire

/* verif/alu_model.svh */
// ALU reference model: expected add, sub and signed multiply results from operand bytes
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// two's complement sum, carry out dropped
function automatic logic [DATA_W-1:0] model_add(input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] m);
    logic [DATA_W:0] full;  // one extra bit for the carry
    full = {1'b0, a} + {1'b0, m};
    return full[DATA_W-1:0];  // wraps mod 256
endfunction

// difference via a + ~m + 1, borrow dropped
function automatic logic [DATA_W-1:0] model_sub(input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] m);
    logic [DATA_W:0] full;
    full = {1'b0, a} + {1'b0, ~m} + 1;
    return full[DATA_W-1:0];
endfunction

// signed 8x8 product, full 16 bits
function automatic logic [2*DATA_W-1:0] model_mul(input logic [DATA_W-1:0] q,
                                                  input logic [DATA_W-1:0] m);
    logic signed [2*DATA_W-1:0] qs;  // multiplier, sign-extended
    logic signed [2*DATA_W-1:0] ms;  // multiplicand, sign-extended
    logic signed [2*DATA_W-1:0] p;
    qs = {{DATA_W{q[DATA_W-1]}}, q};
    ms = {{DATA_W{m[DATA_W-1]}}, m};
    p = qs * ms;  // low 16 bits are exact for 8-bit signed inputs
    return p;
endfunction

// high byte is pushed first
function automatic logic [DATA_W-1:0] model_mul_hi(input logic [DATA_W-1:0] q,
                                                   input logic [DATA_W-1:0] m);
    logic [2*DATA_W-1:0] p;
    p = model_mul(q, m);
    return p[2*DATA_W-1:DATA_W];
endfunction

function automatic logic [DATA_W-1:0] model_mul_lo(input logic [DATA_W-1:0] q,
                                                   input logic [DATA_W-1:0] m);
    logic [2*DATA_W-1:0] p;
    p = model_mul(q, m);
    return p[DATA_W-1:0];  // second byte, with done
endfunction

`endif

/* verif/tb_booth_alu.sv */
// testbench for the Booth ALU checking seeded random add, sub and mul against a reference model
`default_nettype none

module tb_booth_alu import alu_pkg::*;;

    localparam int TIMEOUT = 60;            // cycles allowed for any wait
    localparam logic [31:0] SEED = 32'h7e1a_ab9f;

    logic              clk;
    logic              rst_n;
    logic              start;
    op_e               op;
    logic [DATA_W-1:0] inbus;
    logic [DATA_W-1:0] outbus;
    logic              out_valid;
    logic              done;

    int errors;        // failed checks over the run
    int tests_run;
    int tests_failed;
    int test_err0;     // error count when the current test began

    `include "alu_model.svh"

    booth_alu_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .op        (op),
        .inbus     (inbus),
        .outbus    (outbus),
        .out_valid (out_valid),
        .done      (done)
    );

    always #10 clk = ~clk;  // period 20

    // one mismatch line per failed compare
    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [DATA_W-1:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[DATA_W-1:0];
    endfunction

    // start pulse, two operand bytes, then collect bytes until done
    task automatic run_op(input op_e code, input logic [DATA_W-1:0] first,
                          input logic [DATA_W-1:0] second,
                          output logic [DATA_W-1:0] byte0, output logic [DATA_W-1:0] byte1,
                          output int nbytes, output int lat, output logic first_done);
        int cyc;
        bit got_done;
        nbytes = 0;
        lat = 0;
        byte0 = '0;
        byte1 = '0;
        first_done = 1'b0;
        got_done = 1'b0;
        @(negedge clk);
        start = 1'b1;
        op = code;
        @(negedge clk);  // T1
        start = 1'b0;
        op = OP_ADD;
        inbus = first;
        @(negedge clk);  // T2
        inbus = second;
        cyc = 2;
        while (!got_done && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
            inbus = '0;
            if (out_valid) begin
                if (nbytes == 0) begin
                    byte0 = outbus;
                    first_done = done;
                end else if (nbytes == 1) begin
                    byte1 = outbus;
                end
                nbytes++;
            end
            if (done) begin
                got_done = 1'b1;
                lat = cyc;  // cycles since the start cycle
            end
        end
        if (!got_done) begin
            $display("timeout: no done within %0d cycles after start, op 0x%0h", TIMEOUT, code);
            errors++;
        end
    endtask

    task automatic check_addsub(input op_e code, input logic [DATA_W-1:0] a,
                                input logic [DATA_W-1:0] m);
        logic [DATA_W-1:0] b0;
        logic [DATA_W-1:0] b1;
        int n;
        int lat;
        logic fd;
        run_op(code, a, m, b0, b1, n, lat, fd);
        check_value("latency", lat, 4);  // fixed for add and sub
        check_value("byte_count", n, 1);
        check_value("done", {31'b0, fd}, 32'd1);
        if (code == OP_SUB)
            check_value("outbus", {24'b0, b0}, {24'b0, model_sub(a, m)});
        else
            check_value("outbus", {24'b0, b0}, {24'b0, model_add(a, m)});
    endtask

    task automatic check_mul(input logic [DATA_W-1:0] q, input logic [DATA_W-1:0] m);
        logic [DATA_W-1:0] b0;
        logic [DATA_W-1:0] b1;
        int n;
        int lat;
        logic fd;
        run_op(OP_MUL, q, m, b0, b1, n, lat, fd);
        check_value("byte_count", n, 2);
        check_value("done_on_high", {31'b0, fd}, 32'd0);  // done only with the low byte
        check_value("outbus_hi", {24'b0, b0}, {24'b0, model_mul_hi(q, m)});
        check_value("outbus_lo", {24'b0, b1}, {24'b0, model_mul_lo(q, m)});
    endtask

    task automatic begin_test();
        test_err0 = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_err0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: FAIL, %0d errors", name, errors - test_err0);
            tests_failed++;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        op = OP_ADD;
        inbus = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_err0 = 0;
        void'($urandom(SEED));  // seeds the generator for the whole run
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_value("out_valid", {31'b0, out_valid}, 32'd0);
            check_value("done", {31'b0, done}, 32'd0);
        end
        end_test("reset");

        begin_test();
        for (int i = 0; i < 50; i++)
            check_addsub(OP_ADD, rand_byte(), rand_byte());
        end_test("add");

        begin_test();
        for (int i = 0; i < 50; i++)
            check_addsub(OP_SUB, rand_byte(), rand_byte());
        end_test("sub");

        begin_test();
        for (int i = 0; i < 100; i++)
            check_mul(rand_byte(), rand_byte());
        end_test("mul_random");

        begin_test();
        check_mul(8'h80, 8'h80);        // -128 x -128 needs the guard bits
        check_mul(8'h80, 8'h7f);        // -128 x 127
        check_mul(8'h00, rand_byte());  // every add skipped
        check_mul(8'hff, 8'hff);        // -1 x -1
        check_mul(8'h55, 8'haa);        // 85 x -86 with alternating digits
        end_test("mul_corners");

        begin_test();
        @(negedge clk);
        start = 1'b1;
        op = OP_RSVD;
        inbus = rand_byte();
        @(negedge clk);
        start = 1'b0;
        op = OP_ADD;
        for (int i = 0; i < 10; i++) begin
            check_value("out_valid", {31'b0, out_valid}, 32'd0);
            check_value("done", {31'b0, done}, 32'd0);
            @(negedge clk);
        end
        check_addsub(OP_ADD, rand_byte(), rand_byte());  // still alive after op 11
        end_test("reserved_op");

        $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verif
rtl/alu_pkg.sv
rtl/alu_ctrl_if.sv
rtl/booth_control.sv
rtl/booth_datapath.sv
rtl/booth_alu_top.sv
verif/tb_booth_alu.sv

/* Makefile */
# Verilator build and run for the Booth ALU testbench

TOP := tb_booth_alu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f compile.f -Mdir obj_dir

# pass only if the run prints the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
